// File: Makefile
# Verilator flow for the frame streamer
# The simulator's exit status carries pass or fail

TOP := frame_streamer_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f rtl/*.sv testbench/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f

lint:
	verilator --lint-only -Wall --timing --top-module frame_streamer_top -f all.f

clean:
	rm -rf obj_dir

// File: all.f
rtl/stream_pkg.sv
rtl/stream_ram_2p.sv
rtl/sync_fifo.sv
rtl/word_mod_counter.sv
rtl/fifo2axis.sv
rtl/frame_streamer_top.sv
testbench/frame_streamer_tb.sv

// File: rtl/fifo2axis.sv
// Converter from a FIFO read port to an AXI-Stream style output
// Cuts the stream into frames of len_i words by asserting tlast

`timescale 1ns/1ns
`default_nettype none

module fifo2axis (
   input  wire logic                          clk_i,
   input  wire logic                          rst_n_i,

   // Control
   input  wire logic                          en_i,
   input  wire logic [stream_pkg::LEN_W-1:0]  len_i,

   // FIFO side
   input  wire logic                          fifo_empty_i,
   output logic                               fifo_read_o,
   input  wire logic [stream_pkg::DATA_W-1:0] fifo_rdata_i,

   // Stream side
   output logic                               axis_tvalid_o,
   output logic      [stream_pkg::DATA_W-1:0] axis_tdata_o,
   input  wire logic                          axis_tready_i,
   output logic                               axis_tlast_o
);

   import stream_pkg::*;

   logic             pipe_en;
   logic             valid_int;
   logic             last_int;
   logic [LEN_W-1:0] len_m1;
   logic [LEN_W-1:0] word_count;

   // Output register is free when empty or being taken this cycle
   assign pipe_en = en_i & (axis_tready_i | ~axis_tvalid_o);

   // Fetch only when the output slot frees up
   assign fifo_read_o = en_i & ~fifo_empty_i & (~axis_tvalid_o | axis_tready_i);

   assign len_m1 = len_i - 1'b1;

   // Position of the most recent read in its frame
   word_mod_counter word_count_inst (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .en_i   (fifo_read_o),
      .mod_i  (len_m1),
      .count_o(word_count)
   );

   // Internal stage, covers the FIFO read latency
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_int <= 1'b0;
      end else if (pipe_en) begin
         valid_int <= fifo_read_o;
      end
   end

   // The counter only moves on a read, so it stays tied to the word in
   // the internal stage until that word is moved to the output
   assign last_int = valid_int & (word_count == len_m1);

   // Output stage control
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         axis_tvalid_o <= 1'b0;
         axis_tlast_o  <= 1'b0;
      end else if (pipe_en) begin
         axis_tvalid_o <= valid_int;
         axis_tlast_o  <= last_int;
      end
   end

   // Output data word
   always_ff @(posedge clk_i) begin
      if (pipe_en) begin
         axis_tdata_o <= fifo_rdata_i;
      end
   end

endmodule

`default_nettype wire

// File: rtl/frame_streamer_top.sv
// Top of the frame streamer, host writes go into the FIFO
// and come out as a framed stream through the converter

`timescale 1ns/1ns
`default_nettype none

module frame_streamer_top (
   input  wire logic                           clk_i,
   input  wire logic                           rst_n_i,

   // Control
   input  wire logic                           en_i,
   input  wire logic [stream_pkg::LEN_W-1:0]   len_i,

   // Host write side
   input  wire logic                           wr_i,
   input  wire logic [stream_pkg::DATA_W-1:0]  wr_data_i,
   output logic                                full_o,
   output logic      [stream_pkg::LEVEL_W-1:0] level_o,

   // Stream side
   output logic                                axis_tvalid_o,
   output logic      [stream_pkg::DATA_W-1:0]  axis_tdata_o,
   input  wire logic                           axis_tready_i,
   output logic                                axis_tlast_o
);

   import stream_pkg::*;

   logic              fifo_empty;
   logic              fifo_read;
   logic [DATA_W-1:0] fifo_rdata;

   sync_fifo fifo_inst (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_i     (wr_i),
      .wr_data_i(wr_data_i),
      .rd_i     (fifo_read),
      .rd_data_o(fifo_rdata),
      .empty_o  (fifo_empty),
      .full_o   (full_o),
      .level_o  (level_o)
   );

   fifo2axis conv_inst (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .en_i         (en_i),
      .len_i        (len_i),
      .fifo_empty_i (fifo_empty),
      .fifo_read_o  (fifo_read),
      .fifo_rdata_i (fifo_rdata),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tready_i(axis_tready_i),
      .axis_tlast_o (axis_tlast_o)
   );

endmodule

`default_nettype wire

// File: rtl/stream_pkg.sv
// Shared widths and FIFO sizing for the frame streamer
// Imported by every RTL block of the streamer

`default_nettype none

package stream_pkg;

   // Width of one data word
   localparam int DATA_W = 32;

   // Frame length and word counter width, a len of zero is not used
   localparam int LEN_W = 8;

   // FIFO storage geometry
   localparam int FIFO_ADDR_W = 4;
   localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;

   // One extra bit so the level can hold a full count
   localparam int LEVEL_W = FIFO_ADDR_W + 1;

endpackage

`default_nettype wire

// File: rtl/stream_ram_2p.sv
// Two-port storage array for the FIFO, one write port and one read port
// The read port has a registered output that holds while re_i is low

`timescale 1ns/1ns
`default_nettype none

module stream_ram_2p (
   input  wire logic                           clk_i,

   // Write port
   input  wire logic                           we_i,
   input  wire logic [stream_pkg::FIFO_ADDR_W-1:0] waddr_i,
   input  wire logic [stream_pkg::DATA_W-1:0]      wdata_i,

   // Read port
   input  wire logic                           re_i,
   input  wire logic [stream_pkg::FIFO_ADDR_W-1:0] raddr_i,
   output logic      [stream_pkg::DATA_W-1:0]      rdata_o
);

   import stream_pkg::*;

   // Storage array
   logic [DATA_W-1:0] mem [FIFO_DEPTH];

   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // Read register, keeps the last word read until the next read
   always_ff @(posedge clk_i) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

`default_nettype wire

// File: rtl/sync_fifo.sv
// Synchronous FIFO with a level count and empty and full flags
// Read data appears one cycle after the read is sampled

`timescale 1ns/1ns
`default_nettype none

module sync_fifo (
   input  wire logic                           clk_i,
   input  wire logic                           rst_n_i,

   // Write side
   input  wire logic                           wr_i,
   input  wire logic [stream_pkg::DATA_W-1:0]  wr_data_i,

   // Read side
   input  wire logic                           rd_i,
   output logic      [stream_pkg::DATA_W-1:0]  rd_data_o,

   // Status
   output logic                                empty_o,
   output logic                                full_o,
   output logic      [stream_pkg::LEVEL_W-1:0] level_o
);

   import stream_pkg::*;

   logic                   wr_en;
   logic                   rd_en;
   logic [FIFO_ADDR_W-1:0] wr_ptr;
   logic [FIFO_ADDR_W-1:0] rd_ptr;

   // Flags come straight from the occupancy count
   assign empty_o = (level_o == '0);
   assign full_o  = (level_o == LEVEL_W'(FIFO_DEPTH));

   // Drop writes when full and reads when empty
   assign wr_en = wr_i & ~full_o;
   assign rd_en = rd_i & ~empty_o;

   // Pointers wrap naturally at the array size
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
      end else if (wr_en) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_ptr <= '0;
      end else if (rd_en) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Occupancy count
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level_o <= '0;
      end else begin
         case ({wr_en, rd_en})
            2'b10: begin
               level_o <= level_o + 1'b1;
            end
            2'b01: begin
               level_o <= level_o - 1'b1;
            end
            default: begin
               // Both or neither, count unchanged
               level_o <= level_o;
            end
         endcase
      end
   end

   stream_ram_2p ram (
      .clk_i  (clk_i),
      .we_i   (wr_en),
      .waddr_i(wr_ptr),
      .wdata_i(wr_data_i),
      .re_i   (rd_en),
      .raddr_i(rd_ptr),
      .rdata_o(rd_data_o)
   );

endmodule

`default_nettype wire

// File: rtl/word_mod_counter.sv
// Modulo counter that marks each read's position inside its frame
// Resets to all ones so the first enabled count is zero

`timescale 1ns/1ns
`default_nettype none

module word_mod_counter (
   input  wire logic                         clk_i,
   input  wire logic                         rst_n_i,
   input  wire logic                         en_i,
   input  wire logic [stream_pkg::LEN_W-1:0] mod_i,
   output logic      [stream_pkg::LEN_W-1:0] count_o
);

   import stream_pkg::*;

   logic [LEN_W-1:0] count_nxt;

   // Wrap at or past the modulus, which also catches the reset value
   always_comb begin
      if (count_o >= mod_i) begin
         count_nxt = '0;
      end else begin
         count_nxt = count_o + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         count_o <= '1;
      end else if (en_i) begin
         count_o <= count_nxt;
      end
   end

endmodule

`default_nettype wire

// File: testbench/frame_streamer_tb.sv
// Directed testbench for the frame streamer top level
// A queue model of accepted writes checks every stream transfer and its tlast

`timescale 1ns/1ns
`default_nettype none

module frame_streamer_tb;

   import stream_pkg::*;

   localparam int CLK_PERIOD = 20;

   // Cycle budgets of the tests, summed for the watchdog
   localparam int RUN_CYCLES      = 30 + 180 + 160 + 80 + 120;
   localparam int WATCHDOG_CYCLES = RUN_CYCLES + 200;
   localparam int DRAIN_LIMIT     = 100;

   logic               clk_i;
   logic               rst_n_i;
   logic               en_i;
   logic [LEN_W-1:0]   len_i;
   logic               wr_i;
   logic [DATA_W-1:0]  wr_data_i;
   logic               full_o;
   logic [LEVEL_W-1:0] level_o;
   logic               axis_tvalid_o;
   logic [DATA_W-1:0]  axis_tdata_o;
   logic               axis_tready_i;
   logic               axis_tlast_o;

   integer            seed;
   logic [DATA_W-1:0] model_q [$];
   int                xfer_count;
   logic              held_valid;
   logic [DATA_W-1:0] held_data;
   logic              held_last;
   logic [DATA_W-1:0] expected_word;
   logic              expected_last;

   frame_streamer_top DUT (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .en_i         (en_i),
      .len_i        (len_i),
      .wr_i         (wr_i),
      .wr_data_i    (wr_data_i),
      .full_o       (full_o),
      .level_o      (level_o),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tready_i(axis_tready_i),
      .axis_tlast_o (axis_tlast_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Error: %s is %h, expected %h", name, actual, expected);
         abort_run();
      end
   endtask

   // Stream monitor, transfers happen where tvalid and tready are both high
   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         model_q.delete();
         xfer_count = 0;
         held_valid = 1'b0;
      end else begin
         // A stalled word must not move
         if (held_valid) begin
            check_value("axis_tvalid_o", 32'(axis_tvalid_o), 32'd1);
            check_value("axis_tdata_o", axis_tdata_o, held_data);
            check_value("axis_tlast_o", 32'(axis_tlast_o), 32'(held_last));
         end
         if (axis_tvalid_o && axis_tready_i) begin
            if (model_q.size() == 0) begin
               $display("Error: the stream sent a word that was never written");
               abort_run();
            end else begin
               expected_word = model_q.pop_front();
               expected_last = ((xfer_count % int'(len_i)) == (int'(len_i) - 1));
               check_value("axis_tdata_o", axis_tdata_o, expected_word);
               check_value("axis_tlast_o", 32'(axis_tlast_o), 32'(expected_last));
               xfer_count = xfer_count + 1;
            end
         end
         held_valid = axis_tvalid_o && !axis_tready_i;
         held_data  = axis_tdata_o;
         held_last  = axis_tlast_o;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Error: the watchdog expired before the tests finished");
      abort_run();
   end

   // Reset for 5 cycles with the stream stopped and a new frame length
   task automatic apply_reset(input logic [LEN_W-1:0] len);
      @(negedge clk_i);
      rst_n_i       = 1'b0;
      wr_i          = 1'b0;
      en_i          = 1'b0;
      axis_tready_i = 1'b0;
      len_i         = len;
      repeat (5) @(negedge clk_i);
      rst_n_i = 1'b1;
   endtask

   // Model takes the word only while the FIFO can hold it
   task automatic drive_write(input logic [DATA_W-1:0] data);
      wr_i      = 1'b1;
      wr_data_i = data;
      if (model_q.size() < FIFO_DEPTH) begin
         model_q.push_back(data);
      end
   endtask

   task automatic write_burst(input int nwords);
      for (int i = 0; i < nwords; i++) begin
         @(negedge clk_i);
         drive_write($random(seed));
      end
      @(negedge clk_i);
      wr_i = 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (model_q.size() != 0 || axis_tvalid_o) begin
         @(negedge clk_i);
         cycles++;
         if (cycles > DRAIN_LIMIT) begin
            $display("Error: the stream did not drain within %0d cycles", DRAIN_LIMIT);
            abort_run();
         end
      end
      // Nothing may follow once the model is empty
      repeat (3) begin
         @(negedge clk_i);
         check_value("axis_tvalid_o", 32'(axis_tvalid_o), 32'd0);
      end
   endtask

   task automatic test_reset_state();
      logic [DATA_W-1:0] data;
      apply_reset(8'd4);
      en_i          = 1'b1;
      axis_tready_i = 1'b1;
      check_value("axis_tvalid_o", 32'(axis_tvalid_o), 32'd0);
      check_value("axis_tlast_o", 32'(axis_tlast_o), 32'd0);
      check_value("full_o", 32'(full_o), 32'd0);
      check_value("level_o", 32'(level_o), 32'd0);
      data = $random(seed);
      @(negedge clk_i);
      drive_write(data);
      // First edge takes the write, the word shows two edges later
      @(negedge clk_i);
      wr_i = 1'b0;
      check_value("level_o", 32'(level_o), 32'd1);
      check_value("axis_tvalid_o", 32'(axis_tvalid_o), 32'd0);
      @(negedge clk_i);
      check_value("axis_tvalid_o", 32'(axis_tvalid_o), 32'd0);
      @(negedge clk_i);
      check_value("axis_tvalid_o", 32'(axis_tvalid_o), 32'd1);
      check_value("axis_tdata_o", axis_tdata_o, data);
      wait_drain();
   endtask

   task automatic test_frames(input logic [LEN_W-1:0] len, input int nwords);
      apply_reset(len);
      en_i          = 1'b1;
      axis_tready_i = 1'b1;
      write_burst(nwords);
      wait_drain();
      check_value("level_o", 32'(level_o), 32'd0);
   endtask

   task automatic test_back_pressure(input int nwords);
      int          sent;
      int          cycles;
      logic [31:0] rnd;
      sent   = 0;
      cycles = 0;
      apply_reset(8'd3);
      en_i = 1'b1;
      while (sent < nwords || model_q.size() != 0 || axis_tvalid_o) begin
         @(negedge clk_i);
         rnd           = $random(seed);
         axis_tready_i = rnd[0];
         if (sent < nwords && model_q.size() < FIFO_DEPTH) begin
            drive_write($random(seed));
            sent++;
         end else begin
            wr_i = 1'b0;
         end
         cycles++;
         if (cycles > 4 * DRAIN_LIMIT) begin
            $display("Error: the stream stalled under back-pressure");
            abort_run();
         end
      end
      check_value("level_o", 32'(level_o), 32'd0);
   endtask

   task automatic test_full_fifo();
      apply_reset(8'd4);
      axis_tready_i = 1'b1;
      // Four words past the depth are dropped
      write_burst(FIFO_DEPTH + 4);
      check_value("level_o", 32'(level_o), 32'(FIFO_DEPTH));
      check_value("full_o", 32'(full_o), 32'd1);
      check_value("axis_tvalid_o", 32'(axis_tvalid_o), 32'd0);
      en_i = 1'b1;
      wait_drain();
      check_value("full_o", 32'(full_o), 32'd0);
      check_value("level_o", 32'(level_o), 32'd0);
   endtask

   task automatic test_enable_gating();
      logic [DATA_W-1:0] data_hold;
      logic              last_hold;
      apply_reset(8'd3);
      en_i          = 1'b1;
      axis_tready_i = 1'b1;
      // Four words leave the stream one word into the second frame
      write_burst(4);
      wait_drain();
      en_i = 1'b0;
      write_burst(8);
      data_hold = axis_tdata_o;
      last_hold = axis_tlast_o;
      // The sink stays ready, so only en keeps the FIFO and output still
      repeat (30) begin
         @(negedge clk_i);
         check_value("level_o", 32'(level_o), 32'd8);
         check_value("axis_tvalid_o", 32'(axis_tvalid_o), 32'd0);
         check_value("axis_tdata_o", axis_tdata_o, data_hold);
         check_value("axis_tlast_o", 32'(axis_tlast_o), 32'(last_hold));
      end
      en_i = 1'b1;
      wait_drain();
      check_value("level_o", 32'(level_o), 32'd0);
   endtask

   initial begin
      clk_i         = 1'b0;
      rst_n_i       = 1'b0;
      en_i          = 1'b0;
      len_i         = 8'd1;
      wr_i          = 1'b0;
      wr_data_i     = '0;
      axis_tready_i = 1'b0;
      seed          = 32'hf4b3_2870;

      test_reset_state();
      test_frames(8'd4, 12);
      test_frames(8'd1, 8);
      test_frames(8'd5, 15);
      test_back_pressure(40);
      test_full_fifo();
      test_enable_gating();

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire
